/* bank_pool.sv */
`timescale 1ns/1ns

`include "psum_defines.svh"

module bank_pool
    import psum_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      big_class,
    input  logic      claim,
    input  bank_idx_t claim_bank,
    input  logic      release_en,
    input  bank_idx_t release_bank,
    output bank_idx_t free_bank,
    output logic      bank_available
);

    // A set bit marks a bank that holds live partial sums
    bank_mask_t occupied;

    // ========================================================================
    // Free-bank search
    // ========================================================================

    // Lowest free index in the requested class wins
    // The loops walk downwards so the last hit is the lowest index
    always_comb begin
        free_bank      = '0;
        bank_available = 1'b0;
        if (big_class) begin
            for (int i = `PSUM_TOTAL_BANKS - 1; i >= `PSUM_SMALL_BANKS; i--) begin
                if (!occupied[i]) begin
                    free_bank      = bank_idx_t'(i);
                    bank_available = 1'b1;
                end
            end
        end else begin
            for (int i = `PSUM_SMALL_BANKS - 1; i >= 0; i--) begin
                if (!occupied[i]) begin
                    free_bank      = bank_idx_t'(i);
                    bank_available = 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Occupancy register
    // ========================================================================

    // Claim and release both land on the clock edge
    // The search above sees the old mask, so a bank freed at this edge
    // only becomes visible to a claim one cycle later
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            occupied <= '0;
        end else begin
            if (release_en) begin
                occupied[release_bank] <= 1'b0;
            end
            if (claim) begin
                occupied[claim_bank] <= 1'b1;
            end
        end
    end

    // The sequencer must never take a bank that still holds data
    claim_of_free_bank: assert property (
        @(posedge clk) disable iff (reset) claim |-> !occupied[claim_bank]);

    // A release always refers to a bank the sequencer claimed earlier
    release_of_used_bank: assert property (
        @(posedge clk) disable iff (reset) release_en |-> occupied[release_bank]);

endmodule

/* op_admit.sv */
`timescale 1ns/1ns

module op_admit
    import psum_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       new_op_request,
    input  seg_len_t   seq1,
    input  seg_count_t seq2,
    input  op_id_t     operation_id,
    input  logic       bank_available,
    input  logic       flush_end,
    output logic       stall,
    output logic       start,
    output logic       big_class,
    output seg_len_t   seg_len,
    output seg_count_t seg_count,
    output logic       op_done,
    output op_id_t     op_done_id
);

    // Set from the accepting edge until the flush of the operation ends
    logic   busy;

    // Id of the operation in flight, handed to op_done_id at the end
    op_id_t op_id;

    // ========================================================================
    // Request handshake
    // ========================================================================

    // Only one operation runs at a time, so a request waits for op_done
    // bank_available is low only if the pool lost track of a bank
    assign start = new_op_request && !busy && bank_available;
    assign stall = new_op_request && (busy || !bank_available);

    // While idle the pool is searched for the incoming request
    // Once busy the stored length decides for the rest of the operation
    assign big_class = busy ? big_segment(seg_len) : big_segment(seq1);

    // ========================================================================
    // Operation state
    // ========================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy    <= 1'b0;
            op_done <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (flush_end) begin
                busy <= 1'b0;
            end
            // Pulse follows the last flush cycle by one clock
            op_done <= flush_end;
        end
    end

    // Length, count and id stay stable for the whole operation
    always_ff @(posedge clk) begin
        if (start) begin
            seg_len   <= seq1;
            seg_count <= seq2;
            op_id     <= operation_id;
        end
        if (flush_end) begin
            op_done_id <= op_id;
        end
    end

    // Zero-length segments or zero segments would never reach a phase end
    nonzero_request: assert property (
        @(posedge clk) disable iff (reset)
        start |-> (seq1 != '0) && (seq2 != '0));

endmodule

/* psum_defines.svh */
`ifndef PSUM_DEFINES_SVH
`define PSUM_DEFINES_SVH

// Small banks take the low indices and the big banks follow them
`define PSUM_SMALL_BANKS      3
`define PSUM_BIG_BANKS        3
`define PSUM_TOTAL_BANKS      (`PSUM_SMALL_BANKS + `PSUM_BIG_BANKS)

// Longest segment that still fits in a small bank
`define PSUM_SMALL_THRESHOLD  16

// Field widths shared by the admission stage, the sequencer and the pool
`define PSUM_ADDR_WIDTH       8
`define PSUM_OP_ID_WIDTH      8
`define PSUM_SEG_COUNT_WIDTH  16
`define PSUM_BANK_WIDTH       3

`endif

/* psum_manager.sv */
`timescale 1ns/1ns

module psum_manager
    import psum_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       new_op_request,
    input  seg_len_t   seq1,
    input  seg_count_t seq2,
    input  op_id_t     operation_id,
    output bank_idx_t  selected_bank,
    output logic       assign_valid,
    output logic       write_valid,
    output seg_len_t   write_address,
    output logic       read_valid,
    output bank_idx_t  read_bank_index,
    output seg_len_t   read_address,
    output logic       stall,
    output logic       op_done,
    output op_id_t     op_done_id
);

    // Admission stage to sequencer
    logic       start;
    seg_len_t   seg_len;
    seg_count_t seg_count;
    logic       flush_end;

    // Pool search result and the class it was searched for
    logic       big_class;
    bank_idx_t  free_bank;
    logic       bank_available;

    // Sequencer requests into the pool
    logic       claim;
    bank_idx_t  claim_bank;
    logic       release_en;
    bank_idx_t  release_bank;

    // ========================================================================
    // Admission stage
    // ========================================================================

    op_admit u_op_admit (
        .clk            (clk),
        .reset          (reset),
        .new_op_request (new_op_request),
        .seq1           (seq1),
        .seq2           (seq2),
        .operation_id   (operation_id),
        .bank_available (bank_available),
        .flush_end      (flush_end),
        .stall          (stall),
        .start          (start),
        .big_class      (big_class),
        .seg_len        (seg_len),
        .seg_count      (seg_count),
        .op_done        (op_done),
        .op_done_id     (op_done_id)
    );

    // ========================================================================
    // Shared bank pool
    // ========================================================================

    bank_pool u_bank_pool (
        .clk            (clk),
        .reset          (reset),
        .big_class      (big_class),
        .claim          (claim),
        .claim_bank     (claim_bank),
        .release_en     (release_en),
        .release_bank   (release_bank),
        .free_bank      (free_bank),
        .bank_available (bank_available)
    );

    // ========================================================================
    // Phase sequencing stage
    // ========================================================================

    segment_sequencer u_segment_sequencer (
        .clk             (clk),
        .reset           (reset),
        .start           (start),
        .seg_len         (seg_len),
        .seg_count       (seg_count),
        .free_bank       (free_bank),
        .bank_available  (bank_available),
        .claim           (claim),
        .claim_bank      (claim_bank),
        .release_en      (release_en),
        .release_bank    (release_bank),
        .selected_bank   (selected_bank),
        .assign_valid    (assign_valid),
        .write_valid     (write_valid),
        .write_address   (write_address),
        .read_valid      (read_valid),
        .read_bank_index (read_bank_index),
        .read_address    (read_address),
        .flush_end       (flush_end)
    );

endmodule

/* psum_manager_tb.sv */
`timescale 1ns/1ns

`include "psum_defines.svh"

module psum_manager_tb
    import psum_pkg::*;
();

    logic       clk;
    logic       reset;
    logic       new_op_request;
    seg_len_t   seq1;
    seg_count_t seq2;
    op_id_t     operation_id;
    bank_idx_t  selected_bank;
    logic       assign_valid;
    logic       write_valid;
    seg_len_t   write_address;
    logic       read_valid;
    bank_idx_t  read_bank_index;
    seg_len_t   read_address;
    logic       stall;
    logic       op_done;
    op_id_t     op_done_id;

    // ========================================================================
    // Operation table
    // ========================================================================

    // Each row holds the segment length, the segment count, the id and whether
    // the request is raised while the previous operation is still busy
    localparam int NUM_ROWS = 7;
    int row_len   [NUM_ROWS] = '{1, 16, 17, 4, 17, 3, 20};
    int row_count [NUM_ROWS] = '{1, 4, 4, 2, 1, 4, 2};
    int row_id    [NUM_ROWS] = '{8'h11, 8'h22, 8'h33, 8'h44, 8'h55, 8'h66, 8'h77};
    bit row_busy_arrival [NUM_ROWS] = '{0, 0, 1, 0, 1, 1, 0};
    int row_gap   [NUM_ROWS];

    // The reference model keeps its own occupancy mask and the bank of each phase
    bit [`PSUM_TOTAL_BANKS-1:0] model_mask;
    int phase_bank [0:7];

    bit [15:0] lfsr_state = 16'd89;
    bit        request_pending;
    int        cycle_count = 0;
    int        cycle_limit;

    psum_manager DUT (
        .clk             (clk),
        .reset           (reset),
        .new_op_request  (new_op_request),
        .seq1            (seq1),
        .seq2            (seq2),
        .operation_id    (operation_id),
        .selected_bank   (selected_bank),
        .assign_valid    (assign_valid),
        .write_valid     (write_valid),
        .write_address   (write_address),
        .read_valid      (read_valid),
        .read_bank_index (read_bank_index),
        .read_address    (read_address),
        .stall           (stall),
        .op_done         (op_done),
        .op_done_id      (op_done_id)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Watchdog on the total cycle budget
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $fatal(1, "cycle budget exhausted");
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    // Galois LFSR with taps 16,14,13,11
    function automatic bit [15:0] lfsr_next(bit [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Takes one LFSR output bit per step
    task automatic draw_bits(input int n, output int value);
        value = 0;
        for (int i = 0; i < n; i++) begin
            value = (value << 1) | lfsr_state[0];
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // Lowest free bank in the class that a segment of this length uses
    // Returns -1 when every bank of that class is taken
    function automatic int lowest_free(bit [`PSUM_TOTAL_BANKS-1:0] mask, int len);
        int first;
        int count;
        int result;
        if (len > `PSUM_SMALL_THRESHOLD) begin
            first = `PSUM_SMALL_BANKS;
            count = `PSUM_BIG_BANKS;
        end else begin
            first = 0;
            count = `PSUM_SMALL_BANKS;
        end
        result = -1;
        for (int i = first; i < first + count; i++) begin
            if (result < 0 && !mask[i]) begin
                result = i;
            end
        end
        return result;
    endfunction

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
            $display("TESTBENCH FAILED");
            $fatal(1, "first mismatch ends the run");
        end
    endtask

    // All control outputs stay low while nothing is requested or running
    task automatic check_idle();
        compare("assign_valid", assign_valid, 0);
        compare("write_valid", write_valid, 0);
        compare("read_valid", read_valid, 0);
        compare("stall", stall, 0);
        compare("op_done", op_done, 0);
    endtask

    task automatic drive_request(input int r);
        new_op_request <= 1'b1;
        seq1           <= seg_len_t'(row_len[r]);
        seq2           <= seg_count_t'(row_count[r]);
        operation_id   <= op_id_t'(row_id[r]);
    endtask

    // Claim at each phase start sees the mask before that edge's release,
    // so the bank of phase k-2 is only freed after phase k has chosen
    task automatic plan_banks(input int r);
        for (int k = 1; k <= row_count[r]; k++) begin
            phase_bank[k] = lowest_free(model_mask, row_len[r]);
            if (phase_bank[k] < 0) begin
                $display("reference model found no free bank for row %0d", r);
                $display("TESTBENCH FAILED");
                $fatal(1, "bank model exhausted");
            end
            if (k >= 3) model_mask[phase_bank[k - 2]] = 1'b0;
            model_mask[phase_bank[k]] = 1'b1;
        end
        // The last write phase frees its read bank and the flush frees the final one
        if (row_count[r] >= 2) model_mask[phase_bank[row_count[r] - 1]] = 1'b0;
        model_mask[phase_bank[row_count[r]]] = 1'b0;
    endtask

    // ========================================================================
    // One operation, cycle by cycle from the accepting edge
    // ========================================================================

    task automatic run_op(input int r);
        int  len;
        int  cnt;
        int  last;
        int  phase;
        int  elem;
        bit  next_busy;
        bit  stall_exp;
        len = row_len[r];
        cnt = row_count[r];
        last = (cnt + 1) * len + 1;
        next_busy = (r + 1 < NUM_ROWS) && row_busy_arrival[r + 1];
        stall_exp = 1'b0;
        // A request held over from the previous op_done is already accepted
        if (!request_pending) begin
            repeat (row_gap[r]) begin
                @(negedge clk);
                check_idle();
            end
            @(posedge clk);
            drive_request(r);
            @(negedge clk);
            compare("stall", stall, 0);
        end
        plan_banks(r);
        for (int n = 1; n <= last; n++) begin
            @(posedge clk);
            if (n == 1) new_op_request <= 1'b0;
            if (n == 2 && next_busy) begin
                drive_request(r + 1);
                stall_exp = 1'b1;
            end
            @(negedge clk);
            phase = (n - 1) / len + 1;
            elem = (n - 1) % len;
            compare("assign_valid", assign_valid, (n <= cnt * len) && (elem == 0));
            if (n <= cnt * len && elem == 0) compare("selected_bank", selected_bank,
                                                     phase_bank[phase]);
            compare("write_valid", write_valid, n <= cnt * len);
            if (n <= cnt * len) compare("write_address", write_address, elem);
            compare("read_valid", read_valid, (phase >= 2) && (n <= (cnt + 1) * len));
            if (phase >= 2 && n <= (cnt + 1) * len) begin
                compare("read_address", read_address, elem);
                compare("read_bank_index", read_bank_index, phase_bank[phase - 1]);
            end
            compare("op_done", op_done, n == last);
            if (n == last) compare("op_done_id", op_done_id, row_id[r]);
            // The waiting request is let through in the op_done cycle
            compare("stall", stall, stall_exp && (n < last));
        end
        request_pending = next_busy;
    endtask

    initial begin
        int total;
        int g;
        reset          = 1'b1;
        new_op_request = 1'b0;
        seq1           = '0;
        seq2           = '0;
        operation_id   = '0;
        model_mask     = '0;
        request_pending = 1'b0;
        total = 0;
        for (int r = 0; r < NUM_ROWS; r++) begin
            draw_bits(3, g);
            row_gap[r] = g + 1;
            total = total + (row_count[r] + 1) * row_len[r] + 1 + row_gap[r];
        end
        cycle_limit = total + 200;
        repeat (16) @(posedge clk);
        reset <= 1'b0;
        repeat (4) begin
            @(negedge clk);
            check_idle();
        end
        for (int r = 0; r < NUM_ROWS; r++) begin
            run_op(r);
        end
        @(negedge clk);
        check_idle();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

/* psum_pkg.sv */
`include "psum_defines.svh"

package psum_pkg;

    // Index of one partial-sum bank
    typedef logic [`PSUM_BANK_WIDTH-1:0]      bank_idx_t;

    // One occupancy flag per bank, bit n belongs to bank n
    typedef logic [`PSUM_TOTAL_BANKS-1:0]     bank_mask_t;

    // Segment length, also used for the element address inside a bank
    typedef logic [`PSUM_ADDR_WIDTH-1:0]      seg_len_t;

    // Number of segments in one operation
    typedef logic [`PSUM_SEG_COUNT_WIDTH-1:0] seg_count_t;

    // Tag the requester attaches to an operation
    typedef logic [`PSUM_OP_ID_WIDTH-1:0]     op_id_t;

    // True when a segment of this length needs one of the big banks
    function automatic logic big_segment(seg_len_t len);
        return len > seg_len_t'(`PSUM_SMALL_THRESHOLD);
    endfunction

endpackage

/* segment_sequencer.sv */
`timescale 1ns/1ns

module segment_sequencer
    import psum_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       start,
    input  seg_len_t   seg_len,
    input  seg_count_t seg_count,
    input  bank_idx_t  free_bank,
    input  logic       bank_available,
    output logic       claim,
    output bank_idx_t  claim_bank,
    output logic       release_en,
    output bank_idx_t  release_bank,
    output bank_idx_t  selected_bank,
    output logic       assign_valid,
    output logic       write_valid,
    output seg_len_t   write_address,
    output logic       read_valid,
    output bank_idx_t  read_bank_index,
    output seg_len_t   read_address,
    output logic       flush_end
);

    // Phase flags
    // writing covers the seq2 write phases, reading covers phases 2 and up
    // plus the flush, and reading alone means the flush is running
    logic       writing;
    logic       reading;

    // Element index within the current phase, shared by read and write
    seg_len_t   elem;
    seg_len_t   last_elem;

    // Segments fully written so far
    seg_count_t seg_done;

    // Decodes of the current cycle
    logic       last_write;
    logic       phase_end;

    // ========================================================================
    // Phase decode
    // ========================================================================

    // seg_len is nonzero for any accepted operation
    assign last_elem  = seg_len - seg_len_t'(1);
    assign phase_end  = (writing || reading) && (elem == last_elem);
    assign last_write = (seg_done == seg_count - seg_count_t'(1));

    // First bank comes at the accepting edge
    // Later banks come at every phase end that still has a segment to write
    assign claim      = start || (phase_end && writing && !last_write);
    assign claim_bank = free_bank;

    // The bank read during a phase is done with once that phase ends
    assign release_en   = phase_end && reading;
    assign release_bank = read_bank_index;

    // Last cycle of the flush phase
    assign flush_end = phase_end && reading && !writing;

    // Reads and writes of a phase walk the same addresses in lockstep
    assign write_valid   = writing;
    assign write_address = elem;
    assign read_valid    = reading;
    assign read_address  = elem;

    // ========================================================================
    // Phase control
    // ========================================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            writing      <= 1'b0;
            reading      <= 1'b0;
            elem         <= '0;
            seg_done     <= '0;
            assign_valid <= 1'b0;
        end else begin
            // A new bank is reported in the cycle after its claim
            assign_valid <= claim;
            if (start) begin
                writing  <= 1'b1;
                reading  <= 1'b0;
                elem     <= '0;
                seg_done <= '0;
            end else if (phase_end) begin
                elem <= '0;
                if (writing) begin
                    // The segment just written is read in the next phase
                    seg_done <= seg_done + seg_count_t'(1);
                    reading  <= 1'b1;
                    if (last_write) begin
                        // No more segments so the next phase is the flush
                        writing <= 1'b0;
                    end
                end else begin
                    // Flush finished and the operation is over
                    reading <= 1'b0;
                end
            end else if (writing || reading) begin
                elem <= elem + seg_len_t'(1);
            end
        end
    end

    // Bank registers only matter while the matching valid is high
    always_ff @(posedge clk) begin
        if (claim) begin
            selected_bank <= free_bank;
        end
        if (phase_end && writing) begin
            // Written bank turns into the read bank for the next phase
            read_bank_index <= selected_bank;
        end
    end

    // With two banks busy per class the pool always has a third one ready
    claim_has_bank: assert property (
        @(posedge clk) disable iff (reset) claim |-> bank_available);

endmodule

/* verilog.f */
+incdir+.
psum_pkg.sv
bank_pool.sv
op_admit.sv
segment_sequencer.sv
psum_manager.sv
psum_manager_tb.sv
